// File: source/core6809_pkg.sv
/*
 * Shared definitions for the 6809-family core
 * Widths, reset values, condition code bit positions and the enums
 * for sequencer states, ALU operations and accumulator select.
 * Every RTL file refers to these by scoped name.
 */

package core6809_pkg;

  // --------------------------------------------------
  // Bus and register widths
  // --------------------------------------------------

  // Memory address width
  parameter int addr_w = 16;
  // Data bus and 8-bit register width
  parameter int data_w = 8;

  // --------------------------------------------------
  // Reset values
  // --------------------------------------------------

  // High byte of the reset vector, low byte follows
  parameter logic [addr_w-1:0] vector_addr_dflt = 16'hfffe;
  // E, F and I set out of reset
  parameter logic [data_w-1:0] cc_reset = 8'hd0;

  // --------------------------------------------------
  // Condition code bit positions
  // --------------------------------------------------

  parameter int cc_e = 7;  // Entire state saved
  parameter int cc_f = 6;  // FIRQ mask
  parameter int cc_h = 5;  // Half carry
  parameter int cc_i = 4;  // IRQ mask
  parameter int cc_n = 3;  // Negative
  parameter int cc_z = 2;  // Zero
  parameter int cc_v = 1;  // Overflow
  parameter int cc_c = 0;  // Carry

  // --------------------------------------------------
  // Enumerations
  // --------------------------------------------------

  // Fetch FSM, one memory access per state
  typedef enum logic [1:0] {
    st_reset,
    st_vec_msb,
    st_vec_lsb,
    st_fetch
  } seq_state_t;

  // Inherent accumulator operations
  typedef enum logic [2:0] {
    op_none,
    op_clr,
    op_inc,
    op_asl,
    op_asr
  } alu_op_t;

  // Target accumulator
  typedef enum logic {
    sel_a,
    sel_b
  } acc_sel_t;

endpackage

// File: source/core6809_seq.sv
/*
 * Fetch sequencer and opcode decode
 * Reads the big-endian reset vector, then fetches one opcode byte
 * per clock into the instruction register. The instruction register
 * is decoded into an ALU operation and a target accumulator, which
 * stay valid for the whole cycle after the opcode is captured.
 */

`timescale 1ns/1ps

module core6809_seq #(
  parameter logic [core6809_pkg::addr_w-1:0] vector_addr = core6809_pkg::vector_addr_dflt
) (
  input  logic                            clk,
  input  logic                            reset_b,
  input  logic [core6809_pkg::data_w-1:0] data_in,
  output logic [core6809_pkg::addr_w-1:0] addr,
  output core6809_pkg::alu_op_t           alu_op,
  output core6809_pkg::acc_sel_t          acc_sel
);

  // Opcode high nibbles of the inherent accumulator forms
  localparam logic [3:0] nib_acc_a = 4'h4;
  localparam logic [3:0] nib_acc_b = 4'h5;

  // Opcode low nibbles of the supported operations
  localparam logic [3:0] nib_clr = 4'hf;
  localparam logic [3:0] nib_inc = 4'hc;
  localparam logic [3:0] nib_asl = 4'h8;
  localparam logic [3:0] nib_asr = 4'h7;

  core6809_pkg::seq_state_t state;

  // Address of the next byte to fetch
  logic [core6809_pkg::addr_w-1:0] pc;
  // Opcode currently executing
  logic [core6809_pkg::data_w-1:0] ir;

  // --------------------------------------------------
  // Fetch FSM and address generation
  // --------------------------------------------------

  // addr is registered one step ahead of the byte being captured
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state <= core6809_pkg::st_reset;
      addr  <= vector_addr;
      pc    <= '0;
      ir    <= '0;
    end else begin
      case (state)
        core6809_pkg::st_reset: begin
          // Hold the vector address for one more cycle
          state <= core6809_pkg::st_vec_msb;
          addr  <= vector_addr;
        end
        core6809_pkg::st_vec_msb: begin
          // High vector byte first
          state <= core6809_pkg::st_vec_lsb;
          pc[core6809_pkg::addr_w-1:core6809_pkg::data_w] <= data_in;
          addr  <= vector_addr + 1'b1;
        end
        core6809_pkg::st_vec_lsb: begin
          // Low byte completes the start address
          state <= core6809_pkg::st_fetch;
          pc[core6809_pkg::data_w-1:0] <= data_in;
          addr  <= {pc[core6809_pkg::addr_w-1:core6809_pkg::data_w], data_in};
        end
        core6809_pkg::st_fetch: begin
          // One opcode per clock, wraps at the top of memory
          state <= core6809_pkg::st_fetch;
          ir    <= data_in;
          pc    <= pc + 1'b1;
          addr  <= pc + 1'b1;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Opcode decode
  // --------------------------------------------------

  // Only 4x and 5x inherent forms reach the ALU
  // Reset value of ir decodes to no operation
  always_comb begin
    alu_op  = core6809_pkg::op_none;
    acc_sel = core6809_pkg::sel_a;
    if (ir[7:4] == nib_acc_a || ir[7:4] == nib_acc_b) begin
      if (ir[7:4] == nib_acc_b) begin
        acc_sel = core6809_pkg::sel_b;
      end
      case (ir[3:0])
        nib_clr: alu_op = core6809_pkg::op_clr;
        nib_inc: alu_op = core6809_pkg::op_inc;
        nib_asl: alu_op = core6809_pkg::op_asl;
        nib_asr: alu_op = core6809_pkg::op_asr;
        // Anything else in the row is a no-op here
        default: alu_op = core6809_pkg::op_none;
      endcase
    end
  end

endmodule

// File: source/core6809_acc.sv
/*
 * A and B accumulator file
 * Presents the selected accumulator to the ALU and writes the ALU
 * result back into it whenever an operation is decoded.
 */

`timescale 1ns/1ps

module core6809_acc (
  input  logic                            clk,
  input  logic                            reset_b,
  input  core6809_pkg::acc_sel_t          acc_sel,
  input  core6809_pkg::alu_op_t           alu_op,
  input  logic [core6809_pkg::data_w-1:0] result,
  output logic [core6809_pkg::data_w-1:0] operand,
  output logic [core6809_pkg::data_w-1:0] reg_a,
  output logic [core6809_pkg::data_w-1:0] reg_b
);

  logic [core6809_pkg::data_w-1:0] acc_a;
  logic [core6809_pkg::data_w-1:0] acc_b;
  logic                            write_en;

  // No-op leaves both accumulators alone
  assign write_en = (alu_op != core6809_pkg::op_none);

  // Operand select
  assign operand = (acc_sel == core6809_pkg::sel_b) ? acc_b : acc_a;

  // --------------------------------------------------
  // Writeback
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      acc_a <= '0;
      acc_b <= '0;
    end else if (write_en) begin
      if (acc_sel == core6809_pkg::sel_b) begin
        acc_b <= result;
      end else begin
        acc_a <= result;
      end
    end
  end

  // Register views for the top level
  assign reg_a = acc_a;
  assign reg_b = acc_b;

endmodule

// File: source/core6809_alu.sv
/*
 * Accumulator ALU and condition code register
 * Computes CLR, INC, ASL and ASR on the selected operand as a 9-bit
 * outcome, the top bit being the carry. CC is updated on the same
 * edge that the accumulator file writes the result back.
 */

`timescale 1ns/1ps

module core6809_alu (
  input  logic                            clk,
  input  logic                            reset_b,
  input  core6809_pkg::alu_op_t           alu_op,
  input  logic [core6809_pkg::data_w-1:0] operand,
  output logic [core6809_pkg::data_w-1:0] result,
  output logic [core6809_pkg::data_w-1:0] reg_cc
);

  // Result plus carry out
  logic [core6809_pkg::data_w:0]   outcome;
  logic                            carry;
  // Flag update enables
  logic                            flag_update;
  logic                            ov_update;
  logic [core6809_pkg::data_w-1:0] cc_next;

  // --------------------------------------------------
  // Operation
  // --------------------------------------------------

  always_comb begin
    case (alu_op)
      // Zero with carry cleared
      core6809_pkg::op_clr: outcome = '0;
      // Carry out of bit 7
      core6809_pkg::op_inc: outcome = {1'b0, operand} + 1'b1;
      // Old bit 7 lands in the carry
      core6809_pkg::op_asl: outcome = {operand, 1'b0};
      // Sign bit kept, old bit 0 into carry
      core6809_pkg::op_asr: begin
        outcome = {operand[0], operand[core6809_pkg::data_w-1],
                   operand[core6809_pkg::data_w-1:1]};
      end
      // Pass through, never written back
      default: outcome = {1'b0, operand};
    endcase
  end

  assign result = outcome[core6809_pkg::data_w-1:0];
  assign carry  = outcome[core6809_pkg::data_w];

  // --------------------------------------------------
  // Condition codes
  // --------------------------------------------------

  assign flag_update = (alu_op != core6809_pkg::op_none);
  // Shifts leave V alone
  assign ov_update   = (alu_op == core6809_pkg::op_clr) ||
                       (alu_op == core6809_pkg::op_inc);

  always_comb begin
    // Mask and mode bits never change here
    cc_next[core6809_pkg::cc_e] = reg_cc[core6809_pkg::cc_e];
    cc_next[core6809_pkg::cc_f] = reg_cc[core6809_pkg::cc_f];
    cc_next[core6809_pkg::cc_h] = reg_cc[core6809_pkg::cc_h];
    cc_next[core6809_pkg::cc_i] = reg_cc[core6809_pkg::cc_i];
    // Result flags
    cc_next[core6809_pkg::cc_n] = flag_update ? result[core6809_pkg::data_w-1]
                                              : reg_cc[core6809_pkg::cc_n];
    // Z looks at the 8-bit result only
    cc_next[core6809_pkg::cc_z] = flag_update ? (result == '0)
                                              : reg_cc[core6809_pkg::cc_z];
    cc_next[core6809_pkg::cc_c] = flag_update ? carry
                                              : reg_cc[core6809_pkg::cc_c];
    // Overflow when carry and sign disagree
    cc_next[core6809_pkg::cc_v] = ov_update ? (carry ^ result[core6809_pkg::data_w-1])
                                            : reg_cc[core6809_pkg::cc_v];
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      reg_cc <= core6809_pkg::cc_reset;
    end else begin
      reg_cc <= cc_next;
    end
  end

endmodule

// File: source/core6809_top.sv
/*
 * Top level of the 6809-family core
 * Connects the fetch sequencer, the accumulator file and the ALU.
 * Memory is read asynchronously through addr and data_in.
 * A, B and CC are brought out as read-only register views.
 */

`timescale 1ns/1ps

module core6809_top #(
  parameter logic [core6809_pkg::addr_w-1:0] vector_addr = core6809_pkg::vector_addr_dflt
) (
  input  logic                            clk,
  input  logic                            reset_b,
  output logic [core6809_pkg::addr_w-1:0] addr,
  input  logic [core6809_pkg::data_w-1:0] data_in,
  output logic [core6809_pkg::data_w-1:0] reg_a,
  output logic [core6809_pkg::data_w-1:0] reg_b,
  output logic [core6809_pkg::data_w-1:0] reg_cc
);

  // Decoded control from the sequencer
  core6809_pkg::alu_op_t  alu_op;
  core6809_pkg::acc_sel_t acc_sel;

  // Datapath between accumulators and ALU
  logic [core6809_pkg::data_w-1:0] operand;
  logic [core6809_pkg::data_w-1:0] result;

  // --------------------------------------------------
  // Fetch and decode
  // --------------------------------------------------
  core6809_seq #(
    .vector_addr (vector_addr)
  ) core6809_seq_i (
    .clk     (clk),
    .reset_b (reset_b),
    .data_in (data_in),
    .addr    (addr),
    .alu_op  (alu_op),
    .acc_sel (acc_sel)
  );

  // --------------------------------------------------
  // Execute
  // --------------------------------------------------
  core6809_acc core6809_acc_i (
    .clk     (clk),
    .reset_b (reset_b),
    .acc_sel (acc_sel),
    .alu_op  (alu_op),
    .result  (result),
    .operand (operand),
    .reg_a   (reg_a),
    .reg_b   (reg_b)
  );

  core6809_alu core6809_alu_i (
    .clk     (clk),
    .reset_b (reset_b),
    .alu_op  (alu_op),
    .operand (operand),
    .result  (result),
    .reg_cc  (reg_cc)
  );

endmodule

// File: verification/core6809_checker.sv
/*
 * Checker for the 6809-family core
 * Watches addr and the register views on every falling edge.
 * Expected vector, opcodes and register values come from the
 * same data file the testbench loads into memory.
 */

`timescale 1ns/1ps

module core6809_checker (
  input  logic                            clk,
  input  logic                            reset_b,
  input  logic [core6809_pkg::addr_w-1:0] addr,
  input  logic [core6809_pkg::data_w-1:0] reg_a,
  input  logic [core6809_pkg::data_w-1:0] reg_b,
  input  logic [core6809_pkg::data_w-1:0] reg_cc,
  output int                              error_count,
  output int                              runs_done
);

  // Word 0 vector, word 1 count, then {opcode, a, b, cc}
  logic [31:0] words [0:63];
  logic [15:0] vector;
  int          n_ops;
  int          errors = 0;
  int          runs = 0;
  // Rising edges since reset_b went high
  int          edge_n = 0;

  assign error_count = errors;
  assign runs_done   = runs;

  initial begin
    for (int i = 0; i < 64; i++) begin
      words[i] = '0;
    end
    $readmemh("verification/program_input.txt", words);
    vector = words[0][15:0];
    n_ops  = words[1];
  end

  // Compare one value, report on mismatch
  task automatic check_value(input string name, input logic [15:0] exp_val,
                             input logic [15:0] act_val);
    if (act_val !== exp_val) begin
      errors++;
      $display("FAILED time %0t %s expected %h actual %h", $time, name, exp_val, act_val);
    end
  endtask

  // Checks the three register views in one go
  task automatic check_regs(input logic [7:0] exp_a, input logic [7:0] exp_b,
                            input logic [7:0] exp_cc);
    check_value("reg_a", {8'h00, exp_a}, {8'h00, reg_a});
    check_value("reg_b", {8'h00, exp_b}, {8'h00, reg_b});
    check_value("reg_cc", {8'h00, exp_cc}, {8'h00, reg_cc});
  endtask

  always @(posedge clk) begin
    if (!reset_b) begin
      edge_n = 0;
    end else begin
      edge_n = edge_n + 1;
    end
  end

  // --------------------------------------------------
  // Sampling at the falling edge, all outputs settled
  // --------------------------------------------------
  always @(negedge clk) begin
    logic [15:0] exp_addr;
    int          idx;
    if (!reset_b || edge_n == 0) begin
      // Reset state, also held until edge 1
      check_value("addr", 16'hfffe, addr);
      check_regs(8'h00, 8'h00, 8'hd0);
    end else if (edge_n <= 4 + n_ops) begin
      // Vector bytes first, then one opcode per clock
      if (edge_n == 1) begin
        exp_addr = 16'hfffe;
      end else if (edge_n == 2) begin
        exp_addr = 16'hffff;
      end else begin
        exp_addr = vector + 16'(edge_n - 3);
      end
      check_value("addr", exp_addr, addr);
      // Results trail the fetch by one clock
      if (edge_n <= 4) begin
        check_regs(8'h00, 8'h00, 8'hd0);
      end else begin
        idx = 2 + edge_n - 5;
        check_regs(words[idx][23:16], words[idx][15:8], words[idx][7:0]);
      end
      if (edge_n == 4 + n_ops) begin
        runs++;
      end
    end
  end

endmodule

// File: verification/core6809_tb.sv
/*
 * Testbench for the 6809-family core
 * Builds a 64K memory from the program data file, answers addr
 * with data_in shortly after each rising edge and runs the program
 * twice, with a reset pulsed in between. The checker compares.
 */

`timescale 1ns/1ps

module core6809_tb;

  logic        clk;
  logic        reset_b;
  logic [15:0] addr;
  logic [7:0]  data_in;
  logic [7:0]  reg_a;
  logic [7:0]  reg_b;
  logic [7:0]  reg_cc;

  // Memory image and raw file words
  logic [7:0]  mem [0:65535];
  logic [31:0] words [0:63];
  int          n_ops;
  int          other_errors = 0;
  int          error_count;
  int          runs_done;

  // 20 ns period
  always #10 clk = ~clk;

  core6809_top core6809_top_i (
    .clk     (clk),
    .reset_b (reset_b),
    .addr    (addr),
    .data_in (data_in),
    .reg_a   (reg_a),
    .reg_b   (reg_b),
    .reg_cc  (reg_cc)
  );

  core6809_checker core6809_checker_i (
    .clk         (clk),
    .reset_b     (reset_b),
    .addr        (addr),
    .reg_a       (reg_a),
    .reg_b       (reg_b),
    .reg_cc      (reg_cc),
    .error_count (error_count),
    .runs_done   (runs_done)
  );

  // Background bytes, never a 4x or 5x opcode
  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return {2'b00, a[5:0] ^ a[11:6] ^ {2'b00, a[15:12]}};
  endfunction

  // --------------------------------------------------
  // Memory image from the data file
  // --------------------------------------------------
  task automatic load_memory();
    logic [15:0] vector;
    for (int i = 0; i < 64; i++) begin
      words[i] = '0;
    end
    $readmemh("verification/program_input.txt", words);
    n_ops = words[1];
    if (n_ops == 0 || n_ops > 62) begin
      other_errors++;
      $display("Program data file is missing or holds no usable opcode count");
    end else begin
      vector = words[0][15:0];
      for (int i = 0; i < 65536; i++) begin
        mem[16'(i)] = fill_byte(16'(i));
      end
      // Big-endian vector
      mem[16'hfffe] = vector[15:8];
      mem[16'hffff] = vector[7:0];
      for (int i = 0; i < n_ops; i++) begin
        mem[vector + 16'(i)] = words[2 + i][31:24];
      end
      // INC A and INC B right after the program
      // Both accumulators are nonzero when the mid-run reset hits
      for (int i = 0; i < 4; i++) begin
        mem[vector + 16'(n_ops + i)] = i[0] ? 8'h5c : 8'h4c;
      end
    end
  endtask

  // Asynchronous memory read, driven just after the edge
  always @(posedge clk) begin
    #2;
    data_in = mem[addr];
  end

  // Three clocks of reset
  task automatic apply_reset();
    @(posedge clk);
    #2;
    reset_b = 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
    end
    #2;
    reset_b = 1'b1;
  endtask

  // Wait for the checker to finish a run
  task automatic wait_run(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (runs_done < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (runs_done < target) begin
      other_errors++;
      $display("Timed out after %0d cycles waiting for program run %0d", limit, target);
    end
  endtask

  initial begin
    clk     = 1'b0;
    reset_b = 1'b0;
    data_in = 8'h00;
    load_memory();
    if (other_errors == 0) begin
      data_in = mem[16'hfffe];
      apply_reset();
      wait_run(1, n_ops + 20);
      // Mid-run reset, then the same program again
      apply_reset();
      wait_run(2, n_ops + 20);
    end
    $display("Closing: %0d value errors, %0d other errors", error_count, other_errors);
    if (error_count == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verification/program_input.txt
// Word 0 reset vector, word 1 opcode count (hex)
// Then one word per opcode: opcode, A after, B after, CC after
0000c000
00000026
4c0100d0
480200d0
4c0300d0
480600d0
4c0700d0
480e00d0
4c0f00d0
120f00d0
481e00d0
4c1f00d0
483e00d0
4c3f00d0
487e00d0
4c7f00d0
4c8000da
4c8100da
47c000db
3ac000db
47e000da
47f000da
47f800da
47fc00da
47fe00da
47ff00da
4c0000d7
4d0000d7
5f0000d4
5c0001d0
580002d0
580004d0
580008d0
580010d0
580020d0
580040d0
580080d8
580000d5
570000d4
4f0000d4

// File: src.f
source/core6809_pkg.sv
source/core6809_seq.sv
source/core6809_acc.sv
source/core6809_alu.sv
source/core6809_top.sv
verification/core6809_checker.sv
verification/core6809_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Mdir obj_dir
TOP       = core6809_tb
FILELIST  = src.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
